// ==== files.f ====
verilog/rob_pkg.sv
verilog/rob_result_if.sv
verilog/rob_table.sv
verilog/rob_commit.sv
verilog/rob_csr.sv
verilog/rob_top.sv
verif/clk_gen.sv
verif/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the reorder buffer testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module rob_tb -o rob_sim || exit 1
./obj_dir/rob_sim > sim.log 2>&1 ; cat sim.log
grep -q "^Done: no errors$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

// testbench clock and power-on reset
module clk_gen (
    output logic clk,
    output logic arst_n_o
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for two rising edges, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_o = 1'b1;
    end

endmodule

// ==== verif/rob_stim.txt ====
# op and hex fields: D pc rd we br | L n pc | A idx data | S idx n data
# B idx data misp target | W adr data | R adr expected | K ready | C commits | T name
R 0 1
T in_order
D 100 1 1 0
D 104 0 1 0
D 108 3 0 0
D 10c 4 1 0
A 3 44
A 1 11
A 2 22
A 0 aa
C 4
T full
W 0 0
L 10 200
K 0
R 1 10
S 4 10 5000
W 0 1
C 14
T flush
D 300 5 1 0
D 304 0 0 1
D 308 6 1 0
D 30c 7 1 0
A 6 66
A 7 77
A 4 44
B 5 0 1 400
C 16
R 1 0
D 400 8 1 0
A 0 88
C 17
T counters
R 2 17
R 3 1
W 0 3
R 2 0
R 3 0

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

    localparam int wait_limit = 2000;

    logic clk, arst_n;
    logic disp_valid, disp_we, disp_is_br, disp_ready;
    logic [31:0] disp_pc;
    logic [4:0] disp_rd, reg_addr;
    logic [3:0] disp_idx, alu_idx, br_idx;
    logic alu_valid, br_valid, br_misp;
    logic [31:0] alu_data, br_data, br_target;
    logic commit_valid, reg_we, flush;
    logic [31:0] commit_pc, reg_data, redirect_pc;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0] wb_adr;
    logic [31:0] wb_wdat, wb_rdat;

    // reference model, indexed by rob tag
    logic [31:0] exp_pc [16];
    logic [4:0] exp_rd [16];
    logic exp_we [16];
    logic exp_br [16];
    logic exp_done [16];
    logic exp_misp [16];
    logic [31:0] exp_data [16];
    logic [31:0] exp_target [16];
    // tags in program order
    int order_q[$];
    int model_tail = 0;
    int commit_total = 0;
    string test_name = "reset";

    clk_gen clk_gen_inst (.clk(clk), .arst_n_o(arst_n));

    rob_top rob_top_inst (
        .clk(clk), .arst_n_i(arst_n),
        .disp_valid_i(disp_valid), .disp_pc_i(disp_pc), .disp_rd_i(disp_rd),
        .disp_we_i(disp_we), .disp_is_br_i(disp_is_br),
        .disp_ready_o(disp_ready), .disp_idx_o(disp_idx),
        .alu_valid_i(alu_valid), .alu_idx_i(alu_idx), .alu_data_i(alu_data),
        .br_valid_i(br_valid), .br_idx_i(br_idx), .br_data_i(br_data),
        .br_mispredict_i(br_misp), .br_target_i(br_target),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc), .reg_we_o(reg_we),
        .reg_addr_o(reg_addr), .reg_data_o(reg_data),
        .flush_o(flush), .redirect_pc_o(redirect_pc),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            fail_run($sformatf("FAILED %s %s: expected %0h, actual %0h",
                               test_name, what, exp_v, act_v));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            fail_run($sformatf("%s: %s", test_name, what));
        end
    endtask

    // compare every commit against the oldest model entry
    always @(negedge clk) begin : commit_monitor
        int e;
        if (arst_n && commit_valid) begin
            check_true(order_q.size() > 0, "commit with nothing in flight");
            e = order_q.pop_front();
            check_true(exp_done[e], "entry committed before its result");
            check_val("commit pc", exp_pc[e], commit_pc);
            check_val("reg we", 32'(exp_we[e] && exp_rd[e] != 5'd0), 32'(reg_we));
            if (reg_we) begin
                check_val("reg addr", 32'(exp_rd[e]), 32'(reg_addr));
                check_val("reg data", exp_data[e], reg_data);
            end
            check_val("flush", 32'(exp_br[e] && exp_misp[e]), 32'(flush));
            commit_total++;
            if (flush) begin
                check_val("redirect pc", exp_target[e], redirect_pc);
                // younger entries are gone
                order_q.delete();
                model_tail = 0;
            end
        end else if (arst_n) begin
            check_true(!reg_we, "register write without commit");
            check_true(!flush, "flush without commit");
        end
    end

    task automatic dispatch(input logic [31:0] pc, input logic [4:0] rd,
                            input logic we, input logic br);
        int waited;
        waited = 0;
        while (!disp_ready) begin
            waited++;
            check_true(waited < wait_limit, "timeout waiting for dispatch ready");
            @(negedge clk);
        end
        disp_valid = 1'b1;
        disp_pc = pc;
        disp_rd = rd;
        disp_we = we;
        disp_is_br = br;
        check_val("dispatch tag", 32'(model_tail), 32'(disp_idx));
        exp_pc[model_tail] = pc;
        exp_rd[model_tail] = rd;
        exp_we[model_tail] = we;
        exp_br[model_tail] = br;
        exp_done[model_tail] = 1'b0;
        exp_misp[model_tail] = 1'b0;
        order_q.push_back(model_tail);
        model_tail = (model_tail + 1) % 16;
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic alu_result(input logic [3:0] idx, input logic [31:0] data);
        alu_valid = 1'b1;
        alu_idx = idx;
        alu_data = data;
        exp_data[idx] = data;
        exp_done[idx] = 1'b1;
        @(negedge clk);
        alu_valid = 1'b0;
    endtask

    task automatic branch_result(input logic [3:0] idx, input logic [31:0] data,
                                 input logic misp, input logic [31:0] target);
        br_valid = 1'b1;
        br_idx = idx;
        br_data = data;
        br_misp = misp;
        br_target = target;
        exp_data[idx] = data;
        exp_misp[idx] = misp;
        exp_target[idx] = target;
        exp_done[idx] = 1'b1;
        @(negedge clk);
        br_valid = 1'b0;
    endtask

    // classic cycle, held through the cycle after ack so the write lands
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_wdat = dat;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            check_true(waited < wait_limit, "timeout waiting for wishbone ack");
            @(negedge clk);
        end
        rdat = wb_rdat;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    // poll on rising edges while the monitor counts on falling ones
    task automatic wait_commits(input int total);
        int waited;
        waited = 0;
        @(posedge clk);
        while (commit_total < total) begin
            waited++;
            check_true(waited < wait_limit, "timeout waiting for commits");
            @(posedge clk);
        end
        // resume on the drive edge once the csr has seen the last commit
        @(negedge clk);
    endtask

    initial begin
        int fd, waited;
        string line;
        byte op;
        logic [31:0] a, b, c, d, rdat;
        {disp_valid, disp_we, disp_is_br, disp_pc, disp_rd} = '0;
        {alu_valid, alu_idx, alu_data} = '0;
        {br_valid, br_idx, br_data, br_misp, br_target} = '0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_wdat} = '0;
        void'($urandom(87));
        fd = $fopen("verif/rob_stim.txt", "r");
        check_true(fd != 0, "cannot open the stimulus file");
        waited = 0;
        while (!arst_n) begin
            waited++;
            check_true(waited < wait_limit, "timeout waiting for reset release");
            @(negedge clk);
        end
        // quiet outputs straight after reset
        repeat (3) begin
            check_val("commit after reset", 32'd0, 32'(commit_valid));
            check_val("ready after reset", 32'd1, 32'(disp_ready));
            @(negedge clk);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a
                   || line.getc(line.len() - 1) == 8'h0d)) begin
                line = line.substr(0, line.len() - 2);
            end
            if (line.len() < 1 || line.getc(0) == "#") continue;
            op = line.getc(0);
            if (op == "T") begin
                test_name = line.substr(2, line.len() - 1);
                continue;
            end
            {a, b, c, d} = '0;
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", a, b, c, d));
            repeat ($urandom % 3) @(negedge clk);
            case (op)
                "D": dispatch(a, b[4:0], c[0], d[0]);
                "L": for (int i = 0; i < int'(a); i++) begin
                    dispatch(b + 32'(4 * i), 5'((i % 31) + 1), 1'b1, 1'b0);
                end
                "A": alu_result(a[3:0], b);
                "S": for (int i = 0; i < int'(b); i++) begin
                    alu_result(4'(int'(a) + i), c + 32'(i));
                end
                "B": branch_result(a[3:0], b, c[0], d);
                "W": wb_access(1'b1, a[1:0], b, rdat);
                "R": begin
                    wb_access(1'b0, a[1:0], 32'd0, rdat);
                    check_val($sformatf("register %0d", a), b, rdat);
                end
                "K": check_val("dispatch ready", a, 32'(disp_ready));
                "C": wait_commits(int'(a));
                default: check_true(1'b0, "unknown operation in stimulus file");
            endcase
        end
        $fclose(fd);
        repeat (4) @(negedge clk);
        check_true(order_q.size() == 0, "entries left uncommitted");
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  rob_pkg::rob_entry_t            head_i,
    input  logic                           head_valid_i,
    input  logic                           commit_en_i,
    output logic                           retire_o,
    output logic                           flush_o,
    output logic [rob_pkg::xlen-1:0]       redirect_pc_o,
    output logic                           commit_valid_o,
    output logic [rob_pkg::xlen-1:0]       commit_pc_o,
    output logic                           reg_we_o,
    output logic [rob_pkg::reg_addr_w-1:0] reg_addr_o,
    output logic [rob_pkg::xlen-1:0]       reg_data_o
);

    logic head_done;
    logic commit_valid_q;
    logic reg_we_q;
    logic flush_q;

    logic [rob_pkg::xlen-1:0]       commit_pc_q;
    logic [rob_pkg::reg_addr_w-1:0] reg_addr_q;
    logic [rob_pkg::xlen-1:0]       reg_data_q;
    logic [rob_pkg::xlen-1:0]       redirect_q;

    assign head_done = head_valid_i && head_i.valid && (head_i.status == rob_pkg::st_done);

    // one retire every other cycle, blocked while outputs are up
    assign retire_o = head_done && commit_en_i && !commit_valid_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_q <= 1'b0;
            reg_we_q       <= 1'b0;
            flush_q        <= 1'b0;
        end else begin
            commit_valid_q <= retire_o;
            // x0 is hardwired, never written
            reg_we_q       <= retire_o && head_i.rd_we && (head_i.rd != '0);
            // wrong path behind this branch
            flush_q        <= retire_o && head_i.is_br && head_i.mispredict;
        end
    end

    // writeback payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (retire_o) begin
            commit_pc_q <= head_i.pc;
            reg_addr_q  <= head_i.rd;
            reg_data_q  <= head_i.result;
            redirect_q  <= head_i.target;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_pc_o    = commit_pc_q;
    assign reg_we_o       = reg_we_q;
    assign reg_addr_o     = reg_addr_q;
    assign reg_data_o     = reg_data_q;
    assign flush_o        = flush_q;
    assign redirect_pc_o  = redirect_q;

    // table is empty right after the flush edge
    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_o |=> !head_valid_i)
        else $error("rob not emptied by flush");

endmodule

// ==== verilog/rob_csr.sv ====
`timescale 1ns/1ps

module rob_csr (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [rob_pkg::csr_adr_w-1:0]     wb_adr_i,
    input  logic [rob_pkg::xlen-1:0]          wb_dat_i,
    output logic [rob_pkg::xlen-1:0]          wb_dat_o,
    output logic                              wb_ack_o,
    input  logic                              commit_evt_i,
    input  logic                              flush_evt_i,
    input  logic [rob_pkg::rob_cnt_w-1:0]     count_i,
    output logic                              commit_en_o
);

    logic                     ack_q;
    logic [rob_pkg::xlen-1:0] dat_q;
    logic                     commit_en_q;
    logic [rob_pkg::xlen-1:0] commit_cnt_q;
    logic [rob_pkg::xlen-1:0] flush_cnt_q;

    logic                     wb_req;
    logic                     ctrl_wr;
    logic                     cnt_clr;
    logic [rob_pkg::xlen-1:0] rdata;

    assign wb_req  = wb_cyc_i && wb_stb_i;
    // writes land on the ack cycle
    assign ctrl_wr = wb_req && wb_we_i && ack_q && (wb_adr_i == rob_pkg::csr_ctrl_addr);
    assign cnt_clr = ctrl_wr && wb_dat_i[rob_pkg::ctrl_clr_bit];

    // read mux
    always_comb begin
        case (wb_adr_i)
            rob_pkg::csr_ctrl_addr: begin
                rdata = '0;
                rdata[rob_pkg::ctrl_en_bit] = commit_en_q;
            end
            rob_pkg::csr_status_addr:  rdata = rob_pkg::xlen'(count_i);
            rob_pkg::csr_commits_addr: rdata = commit_cnt_q;
            default:                   rdata = flush_cnt_q;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q        <= 1'b0;
            commit_en_q  <= 1'b1;
            commit_cnt_q <= '0;
            flush_cnt_q  <= '0;
        end else begin
            // single cycle ack, one cycle after the request
            ack_q <= wb_req && !ack_q;
            if (ctrl_wr) begin
                commit_en_q <= wb_dat_i[rob_pkg::ctrl_en_bit];
            end
            // clear takes priority over a same cycle event
            if (cnt_clr) begin
                commit_cnt_q <= '0;
                flush_cnt_q  <= '0;
            end else begin
                if (commit_evt_i) begin
                    commit_cnt_q <= commit_cnt_q + 1'b1;
                end
                if (flush_evt_i) begin
                    flush_cnt_q <= flush_cnt_q + 1'b1;
                end
            end
        end
    end

    // read data sampled with the request, shown with ack
    always_ff @(posedge clk) begin
        if (wb_req && !ack_q) begin
            dat_q <= rdata;
        end
    end

    assign wb_ack_o    = ack_q;
    assign wb_dat_o    = dat_q;
    assign commit_en_o = commit_en_q;

    // classic handshake, master keeps cyc and stb up until ack
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |-> wb_req)
        else $error("wishbone request dropped before ack");

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;
    // occupancy needs one more bit to hold a full buffer
    localparam int rob_cnt_w = rob_idx_w + 1;

    // datapath width, rv32
    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // per-entry life cycle
    typedef enum logic [1:0] {
        st_empty = 2'd0,
        st_busy  = 2'd1,
        st_done  = 2'd2
    } rob_status_e;

    // one reorder buffer slot
    typedef struct packed {
        logic                  valid;
        rob_status_e           status;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_we;
        logic                  is_br;
        logic [xlen-1:0]       result;
        // only meaningful for branches
        logic                  mispredict;
        logic [xlen-1:0]       target;
    } rob_entry_t;

    // wishbone word addresses
    localparam int csr_adr_w = 2;
    localparam logic [csr_adr_w-1:0] csr_ctrl_addr    = 2'd0;
    localparam logic [csr_adr_w-1:0] csr_status_addr  = 2'd1;
    localparam logic [csr_adr_w-1:0] csr_commits_addr = 2'd2;
    localparam logic [csr_adr_w-1:0] csr_flushes_addr = 2'd3;

    // control register bits
    localparam int ctrl_en_bit  = 0;
    // write-one, self clearing
    localparam int ctrl_clr_bit = 1;

endpackage

// ==== verilog/rob_result_if.sv ====
`timescale 1ns/1ps

// one functional unit result bus
interface rob_result_if;

    logic                         valid;
    logic [rob_pkg::rob_idx_w-1:0] idx;
    logic [rob_pkg::xlen-1:0]      data;
    // branch only, tied low on alu
    logic                         mispredict;
    logic [rob_pkg::xlen-1:0]      target;

    // functional unit side
    modport drv (
        output valid,
        output idx,
        output data,
        output mispredict,
        output target
    );

    // reorder buffer side, no back-pressure
    modport rcv (
        input valid,
        input idx,
        input data,
        input mispredict,
        input target
    );

endinterface

// ==== verilog/rob_table.sv ====
`timescale 1ns/1ps

module rob_table (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               disp_valid_i,
    input  logic [rob_pkg::xlen-1:0]           disp_pc_i,
    input  logic [rob_pkg::reg_addr_w-1:0]     disp_rd_i,
    input  logic                               disp_we_i,
    input  logic                               disp_is_br_i,
    output logic                               disp_ready_o,
    output logic [rob_pkg::rob_idx_w-1:0]      disp_idx_o,
    rob_result_if.rcv                          alu_res,
    rob_result_if.rcv                          br_res,
    input  logic                               retire_i,
    input  logic                               flush_i,
    output rob_pkg::rob_entry_t                head_o,
    output logic                               head_valid_o,
    output logic [rob_pkg::rob_cnt_w-1:0]      count_o
);

    // control state
    logic [rob_pkg::rob_idx_w-1:0] head_q;
    logic [rob_pkg::rob_idx_w-1:0] tail_q;
    logic [rob_pkg::rob_cnt_w-1:0] count_q;
    rob_pkg::rob_status_e          status_q [rob_pkg::rob_depth];

    // payload storage
    logic [rob_pkg::xlen-1:0]       pc_q     [rob_pkg::rob_depth];
    logic [rob_pkg::reg_addr_w-1:0] rd_q     [rob_pkg::rob_depth];
    logic                           we_q     [rob_pkg::rob_depth];
    logic                           is_br_q  [rob_pkg::rob_depth];
    logic [rob_pkg::xlen-1:0]       result_q [rob_pkg::rob_depth];
    logic                           misp_q   [rob_pkg::rob_depth];
    logic [rob_pkg::xlen-1:0]       target_q [rob_pkg::rob_depth];

    logic full;
    logic disp_fire;

    assign full = (count_q == rob_pkg::rob_cnt_w'(rob_pkg::rob_depth));
    // no allocation while the buffer is being emptied
    assign disp_ready_o = !full && !flush_i;
    assign disp_fire    = disp_valid_i && disp_ready_o;
    // tag handed back in the accepting cycle
    assign disp_idx_o   = tail_q;

    assign count_o      = count_q;
    assign head_valid_o = (count_q != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                status_q[i] <= rob_pkg::st_empty;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // mispredict, drop everything in flight
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                status_q[i] <= rob_pkg::st_empty;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // writeback marks the entry done
            if (alu_res.valid) begin
                status_q[alu_res.idx] <= rob_pkg::st_done;
            end
            if (br_res.valid) begin
                status_q[br_res.idx] <= rob_pkg::st_done;
            end
            // depth is a power of two so pointers wrap on their own
            if (retire_i) begin
                status_q[head_q] <= rob_pkg::st_empty;
                head_q           <= head_q + 1'b1;
            end
            if (disp_fire) begin
                status_q[tail_q] <= rob_pkg::st_busy;
                tail_q           <= tail_q + 1'b1;
            end
            case ({disp_fire, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            pc_q[tail_q]    <= disp_pc_i;
            rd_q[tail_q]    <= disp_rd_i;
            we_q[tail_q]    <= disp_we_i;
            is_br_q[tail_q] <= disp_is_br_i;
            misp_q[tail_q]  <= 1'b0;
        end
        if (alu_res.valid) begin
            result_q[alu_res.idx] <= alu_res.data;
        end
        // branch bus also brings the resolved direction
        if (br_res.valid) begin
            result_q[br_res.idx] <= br_res.data;
            misp_q[br_res.idx]   <= br_res.mispredict;
            target_q[br_res.idx] <= br_res.target;
        end
    end

    // head entry view for commit
    always_comb begin
        head_o.valid      = (status_q[head_q] != rob_pkg::st_empty);
        head_o.status     = status_q[head_q];
        head_o.pc         = pc_q[head_q];
        head_o.rd         = rd_q[head_q];
        head_o.rd_we      = we_q[head_q];
        head_o.is_br      = is_br_q[head_q];
        head_o.result     = result_q[head_q];
        head_o.mispredict = misp_q[head_q];
        head_o.target     = target_q[head_q];
    end

    // results only for allocated entries
    a_alu_live: assert property (@(posedge clk) disable iff (!arst_n_i)
        alu_res.valid |-> status_q[alu_res.idx] != rob_pkg::st_empty)
        else $error("alu result for empty rob entry %0d", alu_res.idx);

    a_br_live: assert property (@(posedge clk) disable iff (!arst_n_i)
        br_res.valid |-> status_q[br_res.idx] != rob_pkg::st_empty)
        else $error("branch result for empty rob entry %0d", br_res.idx);

    a_count_max: assert property (@(posedge clk) disable iff (!arst_n_i)
        count_q <= rob_pkg::rob_cnt_w'(rob_pkg::rob_depth))
        else $error("rob occupancy overflow %0d", count_q);

    // commit stage must wait for completion
    a_retire_done: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_i |-> head_valid_o && status_q[head_q] == rob_pkg::st_done)
        else $error("retire of head %0d before done", head_q);

endmodule

// ==== verilog/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
    input  logic                              clk,
    input  logic                              arst_n_i,
    // dispatch
    input  logic                              disp_valid_i,
    input  logic [rob_pkg::xlen-1:0]          disp_pc_i,
    input  logic [rob_pkg::reg_addr_w-1:0]    disp_rd_i,
    input  logic                              disp_we_i,
    input  logic                              disp_is_br_i,
    output logic                              disp_ready_o,
    output logic [rob_pkg::rob_idx_w-1:0]     disp_idx_o,
    // alu result bus
    input  logic                              alu_valid_i,
    input  logic [rob_pkg::rob_idx_w-1:0]     alu_idx_i,
    input  logic [rob_pkg::xlen-1:0]          alu_data_i,
    // branch result bus
    input  logic                              br_valid_i,
    input  logic [rob_pkg::rob_idx_w-1:0]     br_idx_i,
    input  logic [rob_pkg::xlen-1:0]          br_data_i,
    input  logic                              br_mispredict_i,
    input  logic [rob_pkg::xlen-1:0]          br_target_i,
    // commit
    output logic                              commit_valid_o,
    output logic [rob_pkg::xlen-1:0]          commit_pc_o,
    output logic                              reg_we_o,
    output logic [rob_pkg::reg_addr_w-1:0]    reg_addr_o,
    output logic [rob_pkg::xlen-1:0]          reg_data_o,
    output logic                              flush_o,
    output logic [rob_pkg::xlen-1:0]          redirect_pc_o,
    // wishbone slave
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [rob_pkg::csr_adr_w-1:0]     wb_adr_i,
    input  logic [rob_pkg::xlen-1:0]          wb_dat_i,
    output logic [rob_pkg::xlen-1:0]          wb_dat_o,
    output logic                              wb_ack_o
);

    rob_result_if alu_bus ();
    rob_result_if br_bus ();

    rob_pkg::rob_entry_t           head;
    logic                          head_valid;
    logic                          retire;
    logic                          commit_en;
    logic [rob_pkg::rob_cnt_w-1:0] count;

    assign alu_bus.valid      = alu_valid_i;
    assign alu_bus.idx        = alu_idx_i;
    assign alu_bus.data       = alu_data_i;
    // alu never redirects
    assign alu_bus.mispredict = 1'b0;
    assign alu_bus.target     = '0;

    assign br_bus.valid       = br_valid_i;
    assign br_bus.idx         = br_idx_i;
    assign br_bus.data        = br_data_i;
    assign br_bus.mispredict  = br_mispredict_i;
    assign br_bus.target      = br_target_i;

    rob_table rob_table_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .disp_valid_i (disp_valid_i),
        .disp_pc_i    (disp_pc_i),
        .disp_rd_i    (disp_rd_i),
        .disp_we_i    (disp_we_i),
        .disp_is_br_i (disp_is_br_i),
        .disp_ready_o (disp_ready_o),
        .disp_idx_o   (disp_idx_o),
        .alu_res      (alu_bus),
        .br_res       (br_bus),
        .retire_i     (retire),
        .flush_i      (flush_o),
        .head_o       (head),
        .head_valid_o (head_valid),
        .count_o      (count)
    );

    rob_commit rob_commit_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .head_i         (head),
        .head_valid_i   (head_valid),
        .commit_en_i    (commit_en),
        .retire_o       (retire),
        .flush_o        (flush_o),
        .redirect_pc_o  (redirect_pc_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .reg_we_o       (reg_we_o),
        .reg_addr_o     (reg_addr_o),
        .reg_data_o     (reg_data_o)
    );

    // counters see the registered commit and flush strobes
    rob_csr rob_csr_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .commit_evt_i (commit_valid_o),
        .flush_evt_i  (flush_o),
        .count_i      (count),
        .commit_en_o  (commit_en)
    );

endmodule
